// ==== source/ein_pkg.sv ====
// Shared widths and encodings for the link port.
package ein_pkg;

	// Width of one host bus byte.
	localparam int byte_w = 8;

	// First byte of the acknowledge message sent back to the host.
	typedef enum logic [7:0] {
		MSG_ACK = 8'h06,
		MSG_NAK = 8'h15
	} msg_kind_e;

	// Header decoder states.
	typedef enum logic [1:0] {
		HDR_EID,
		HDR_FLAGS,
		HDR_DONE,
		HDR_DRAIN
	} hdr_state_e;

	// Pad modulator states.
	typedef enum logic [1:0] {
		MOD_IDLE,
		MOD_BITS,
		MOD_CHAR_END,
		MOD_MSG_END
	} mod_state_e;

	// Frame controller states.
	typedef enum logic [1:0] {
		CTL_IDLE,
		CTL_TRANSMIT,
		CTL_ACK
	} ctl_state_e;

endpackage

// ==== source/frame_buffer.sv ====
module frame_buffer
	import ein_pkg::*;
#(
	parameter int fifo_depth = 16
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [byte_w-1:0] in_data,
	input  logic              in_last,
	input  logic              in_valid,
	output logic              in_ready,
	output logic [byte_w-1:0] buf_data,
	output logic              buf_last,
	output logic              buf_valid,
	input  logic              buf_pop
);

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
	localparam int cnt_w = $clog2(fifo_depth + 1);

	// Each entry keeps the last flag above the data byte.
	logic [byte_w:0]  mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic [cnt_w-1:0] count_next;
	logic             wr_en;

	function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(fifo_depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign wr_en = in_valid && in_ready;
	assign count_next = count + cnt_w'(wr_en) - cnt_w'(buf_pop);

	assign buf_valid = (count != '0);
	assign buf_data = mem[rd_ptr][byte_w-1:0];
	assign buf_last = mem[rd_ptr][byte_w];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= {in_last, in_data};
		end
	end

	// Ready is registered from the next fill level, so it stays low through reset.
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in_ready <= 1'b0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (buf_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count_next;
			in_ready <= (count_next != cnt_w'(fifo_depth));
		end
	end

	// The consumers must only pop what the buffer presents.
	a_pop_not_empty: assert property (@(posedge clk) disable iff (reset)
		buf_pop |-> buf_valid)
		else $error("frame_buffer popped while empty");

	// A full buffer has both pointers on the same entry with a nonzero count.
	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		wr_en |-> !((wr_ptr == rd_ptr) && (count != '0)))
		else $error("frame_buffer written while full");

endmodule

// ==== source/header_decoder.sv ====
module header_decoder
	import ein_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic [byte_w-1:0] buf_data,
	input  logic              buf_last,
	input  logic              buf_valid,
	input  logic              hdr_enable,
	input  logic              hdr_clear,
	output logic              hdr_pop,
	output logic [byte_w-1:0] hdr_eid,
	output logic              hdr_fragment,
	output logic              hdr_done,
	output logic              hdr_bad
);

	hdr_state_e state;

	// Header bytes are taken one per cycle while the controller allows it.
	assign hdr_pop = hdr_enable && buf_valid && (state == HDR_EID || state == HDR_FLAGS);

	assign hdr_done = (state == HDR_DONE);
	assign hdr_bad = (state == HDR_DRAIN);

	// A truncated frame has already given up its last byte when the bad
	// state is entered, so nothing of it remains in the buffer.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= HDR_EID;
		end else begin
			case (state)
				HDR_EID: begin
					if (hdr_pop) begin
						state <= buf_last ? HDR_DRAIN : HDR_FLAGS;
					end
				end
				HDR_FLAGS: begin
					if (hdr_pop) begin
						state <= buf_last ? HDR_DRAIN : HDR_DONE;
					end
				end
				HDR_DONE, HDR_DRAIN: begin
					if (hdr_clear) begin
						state <= HDR_EID;
					end
				end
				default: begin
					state <= HDR_EID;
				end
			endcase
		end
	end

	// A frame that ends on its eid byte reports eid zero.
	always_ff @(posedge clk) begin
		if (hdr_pop && state == HDR_EID) begin
			hdr_eid <= buf_last ? '0 : buf_data;
		end
		if (hdr_pop && state == HDR_FLAGS) begin
			hdr_fragment <= buf_data[0];
		end
	end

endmodule

// ==== source/ein_modulator.sv ====
module ein_modulator
	import ein_pkg::*;
#(
	parameter int step_cycles = 4000
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [byte_w-1:0] buf_data,
	input  logic              buf_last,
	input  logic              buf_valid,
	input  logic              start_tx,
	input  logic              fragment,
	output logic              mod_pop,
	output logic              tx_done,
	output logic              emo_pad,
	output logic              edi_pad,
	output logic              eci_pad
);

	localparam int cnt_w = $clog2(step_cycles + 1);
	localparam int idx_w = $clog2(byte_w);

	mod_state_e        state;
	logic [cnt_w-1:0]  step_cnt;
	logic              step_due;
	logic              pad_step;
	logic [byte_w-1:0] shift;
	logic [idx_w-1:0]  bit_idx;
	logic              char_ok;
	logic              last_q;
	logic              mark_pend;

	// The counter runs down after each toggle, so toggles are step_cycles apart.
	assign step_due = (step_cnt == '0);

	assign pad_step = step_due && ((state == MOD_BITS && char_ok) ||
		state == MOD_CHAR_END || (state == MOD_MSG_END && mark_pend));

	assign mod_pop = (state == MOD_BITS) && !char_ok && buf_valid;

	// Done once the final step has run its full length.
	assign tx_done = (state == MOD_MSG_END) && step_due && !mark_pend;

	always_ff @(posedge clk) begin
		if (reset) begin
			step_cnt <= '0;
		end else if (pad_step) begin
			step_cnt <= cnt_w'(step_cycles - 1);
		end else if (!step_due) begin
			step_cnt <= step_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= MOD_IDLE;
			char_ok <= 1'b0;
			mark_pend <= 1'b0;
			bit_idx <= '0;
			emo_pad <= 1'b0;
			edi_pad <= 1'b0;
			eci_pad <= 1'b0;
		end else begin
			case (state)
				MOD_IDLE: begin
					if (start_tx) begin
						mark_pend <= !fragment;
						char_ok <= 1'b0;
						state <= MOD_BITS;
					end
				end
				MOD_BITS: begin
					if (mod_pop) begin
						char_ok <= 1'b1;
						bit_idx <= '0;
					end else if (pad_step) begin
						// A one goes out on emo, a zero on edi.
						if (shift[byte_w-1]) begin
							emo_pad <= !emo_pad;
						end else begin
							edi_pad <= !edi_pad;
						end
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == idx_w'(byte_w - 1)) begin
							state <= MOD_CHAR_END;
						end
					end
				end
				MOD_CHAR_END: begin
					if (pad_step) begin
						eci_pad <= !eci_pad;
						char_ok <= 1'b0;
						state <= last_q ? MOD_MSG_END : MOD_BITS;
					end
				end
				MOD_MSG_END: begin
					if (pad_step) begin
						eci_pad <= !eci_pad;
						mark_pend <= 1'b0;
					end else if (tx_done) begin
						state <= MOD_IDLE;
					end
				end
				default: begin
					state <= MOD_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (mod_pop) begin
			shift <= buf_data;
			last_q <= buf_last;
		end else if (state == MOD_BITS && pad_step) begin
			shift <= shift << 1;
		end
	end

	a_one_wire: assert property (@(posedge clk) disable iff (reset)
		$countones({emo_pad, edi_pad, eci_pad} ^ $past({emo_pad, edi_pad, eci_pad})) <= 1)
		else $error("ein_modulator changed more than one pad on one edge");

endmodule

// ==== source/ack_generator.sv ====
module ack_generator
	import ein_pkg::*;
(
	input  logic              clk,
	input  logic              reset,
	input  logic              ack_send,
	input  msg_kind_e         ack_kind,
	input  logic [byte_w-1:0] ack_eid,
	input  logic              ack_ready,
	output logic [byte_w-1:0] ack_data,
	output logic              ack_last,
	output logic              ack_valid,
	output logic              ack_busy
);

	msg_kind_e         kind_q;
	logic [byte_w-1:0] eid_q;
	logic              busy;
	logic              second;

	// The kind byte goes first, the eid byte closes the message.
	assign ack_valid = busy;
	assign ack_busy = busy;
	assign ack_last = second;
	assign ack_data = second ? eid_q : byte_w'(kind_q);

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			second <= 1'b0;
		end else if (ack_send) begin
			busy <= 1'b1;
			second <= 1'b0;
		end else if (busy && ack_ready) begin
			if (second) begin
				busy <= 1'b0;
				second <= 1'b0;
			end else begin
				second <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ack_send) begin
			kind_q <= ack_kind;
			eid_q <= ack_eid;
		end
	end

	// The controller must not start a new message while one is in flight.
	a_hold_stable: assert property (@(posedge clk) disable iff (reset)
		(ack_valid && !ack_ready) |=> (ack_valid && $stable(ack_data) && $stable(ack_last)))
		else $error("ack_generator changed a byte under back-pressure");

endmodule

// ==== source/ein_int.sv ====
module ein_int
	import ein_pkg::*;
#(
	parameter int fifo_depth = 16,
	parameter int step_cycles = 4000
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [byte_w-1:0] in_data,
	input  logic              in_last,
	input  logic              in_valid,
	output logic              in_ready,
	output logic [byte_w-1:0] ack_data,
	output logic              ack_last,
	output logic              ack_valid,
	input  logic              ack_ready,
	output logic              emo_pad,
	output logic              edi_pad,
	output logic              eci_pad
);

	logic [byte_w-1:0] buf_data;
	logic              buf_last;
	logic              buf_valid;
	logic              buf_pop;
	logic              hdr_pop;
	logic              mod_pop;
	logic              hdr_enable;
	logic              hdr_clear;
	logic [byte_w-1:0] hdr_eid;
	logic              hdr_fragment;
	logic              hdr_done;
	logic              hdr_bad;
	logic              start_tx;
	logic              tx_done;
	logic              ack_send;
	msg_kind_e         ack_kind;
	logic              ack_busy;
	ctl_state_e        state;
	ctl_state_e        next_state;

	// The decoder pops only in idle and the modulator only while transmitting.
	assign buf_pop = hdr_pop | mod_pop;

	frame_buffer #(.fifo_depth(fifo_depth)) u_buffer (
		.clk, .reset, .in_data, .in_last, .in_valid, .in_ready,
		.buf_data, .buf_last, .buf_valid, .buf_pop
	);

	header_decoder u_decoder (
		.clk, .reset, .buf_data, .buf_last, .buf_valid, .hdr_enable, .hdr_clear,
		.hdr_pop, .hdr_eid, .hdr_fragment, .hdr_done, .hdr_bad
	);

	ein_modulator #(.step_cycles(step_cycles)) u_modulator (
		.clk, .reset, .buf_data, .buf_last, .buf_valid, .start_tx,
		.fragment(hdr_fragment), .mod_pop, .tx_done, .emo_pad, .edi_pad, .eci_pad
	);

	ack_generator u_ack (
		.clk, .reset, .ack_send, .ack_kind, .ack_eid(hdr_eid), .ack_ready,
		.ack_data, .ack_last, .ack_valid, .ack_busy
	);

	always_comb begin
		next_state = state;
		hdr_enable = 1'b0;
		hdr_clear = 1'b0;
		start_tx = 1'b0;
		ack_send = 1'b0;
		ack_kind = MSG_ACK;
		case (state)
			CTL_IDLE: begin
				hdr_enable = 1'b1;
				if (hdr_done) begin
					hdr_clear = 1'b1;
					start_tx = 1'b1;
					next_state = CTL_TRANSMIT;
				end else if (hdr_bad) begin
					// A broken header never reaches the pads.
					hdr_clear = 1'b1;
					ack_send = 1'b1;
					ack_kind = MSG_NAK;
					next_state = CTL_ACK;
				end
			end
			CTL_TRANSMIT: begin
				if (tx_done) begin
					ack_send = 1'b1;
					next_state = CTL_ACK;
				end
			end
			CTL_ACK: begin
				if (!ack_busy) begin
					next_state = CTL_IDLE;
				end
			end
			default: begin
				next_state = CTL_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= CTL_IDLE;
		end else begin
			state <= next_state;
		end
	end

	a_single_reader: assert property (@(posedge clk) disable iff (reset)
		!(hdr_pop && mod_pop))
		else $error("decoder and modulator popped the buffer together");

endmodule

// ==== testbench/ein_int_tb.sv ====
module ein_int_tb;

	localparam int frame_count = 12;
	localparam int step_cycles = 3;
	localparam int end_mark = 256;
	localparam logic [7:0] ack_code = 8'h06;
	localparam logic [7:0] nak_code = 8'h15;

	logic       clk = 1'b0;
	logic       reset = 1'b1;
	logic [7:0] in_data = 8'h00;
	logic       in_last = 1'b0;
	logic       in_valid = 1'b0;
	logic       in_ready;
	logic [7:0] ack_data;
	logic       ack_last;
	logic       ack_valid;
	logic       ack_ready = 1'b0;
	logic       emo_pad;
	logic       edi_pad;
	logic       eci_pad;

	// Host bytes carry last on bit 8. Pad events are characters, or end_mark for a message end.
	logic [8:0]  stream_q[$];
	int          event_q[$];
	logic [15:0] ack_q[$];
	int          ack_total = 0;
	int          acks_seen = 0;
	int          payload_steps = 0;
	int          timeout_limit = 0;
	int          cycle_cnt = 0;
	int          reset_edges = 0;
	int          char_bits = 0;
	logic [7:0]  char_val = 8'h00;
	logic [2:0]  prev_pads = 3'b000;
	logic        after_reset = 1'b1;
	logic        ack_second = 1'b0;
	logic        ack_hold = 1'b0;
	logic [7:0]  held_data = 8'h00;
	logic        held_last = 1'b0;

	ein_int #(.fifo_depth(8), .step_cycles(step_cycles)) u_dut (
		.clk, .reset, .in_data, .in_last, .in_valid, .in_ready, .ack_data, .ack_last,
		.ack_valid, .ack_ready, .emo_pad, .edi_pad, .eci_pad
	);

	always #50 clk = ~clk;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input int expected, input int actual);
		stop_with_failure($sformatf("MISMATCH time %0t: %s expected 0x%0h, actual 0x%0h",
			$time, name, expected, actual));
	endtask

	task automatic match_pad_event(input string name, input int actual);
		if (event_q.size() == 0) begin
			stop_with_failure("A pad symbol arrived when no symbol was expected.");
		end else begin
			assert (event_q[0] == actual) else report_mismatch(name, event_q[0], actual);
			void'(event_q.pop_front());
		end
	endtask

	// Frame 3 ends on its eid byte and frame 8 ends on its flags byte.
	task automatic build_frames();
		int n;
		logic [7:0] eid;
		logic [7:0] flags;
		logic [7:0] data;
		for (int f = 0; f < frame_count; f++) begin
			eid = 8'($urandom);
			flags = 8'($urandom);
			if (f == 3) begin
				stream_q.push_back({1'b1, eid});
				ack_q.push_back({nak_code, 8'h00});
			end else if (f == 8) begin
				stream_q.push_back({1'b0, eid});
				stream_q.push_back({1'b1, flags});
				ack_q.push_back({nak_code, eid});
			end else begin
				n = 1 + int'($urandom_range(4));
				stream_q.push_back({1'b0, eid});
				stream_q.push_back({1'b0, flags});
				for (int b = 0; b < n; b++) begin
					data = 8'($urandom);
					stream_q.push_back({(b == n - 1), data});
					event_q.push_back(int'(data));
				end
				payload_steps += 9 * n;
				if (!flags[0]) begin
					event_q.push_back(end_mark);
					payload_steps += 1;
				end
				ack_q.push_back({ack_code, eid});
			end
		end
		ack_total = ack_q.size();
	endtask

	initial begin
		void'($urandom(57));
		build_frames();
		timeout_limit = payload_steps * step_cycles + 200 * frame_count;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		foreach (stream_q[i]) begin
			if ($urandom_range(3) == 0) begin
				in_valid <= 1'b0;
				@(posedge clk);
			end
			in_data <= stream_q[i][7:0];
			in_last <= stream_q[i][8];
			in_valid <= 1'b1;
			@(posedge clk);
			while (!in_ready) begin
				@(posedge clk);
			end
		end
		in_valid <= 1'b0;
		while (acks_seen < ack_total) begin
			@(posedge clk);
		end
		if (event_q.size() != 0 || ack_q.size() != 0) begin
			stop_with_failure(
				"The run ended with expected pad symbols or acknowledges left over.");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

	// The acknowledge consumer stalls about a third of the time.
	always @(posedge clk) begin
		ack_ready <= !reset && ($urandom_range(2) != 0);
	end

	// The pad decoder takes emo and edi toggles as data bits, and an eci toggle
	// closes a character or a message.
	always @(posedge clk) begin
		logic [2:0] pads;
		logic [2:0] diff;
		pads = {emo_pad, edi_pad, eci_pad};
		diff = pads ^ prev_pads;
		if (reset || after_reset) begin
			if (reset_edges > 0) begin
				assert (pads == 3'b000) else report_mismatch("pads", 0, int'(pads));
				assert (!ack_valid) else report_mismatch("ack_valid", 0, int'(ack_valid));
				assert (!in_ready) else report_mismatch("in_ready", 0, int'(in_ready));
			end
			reset_edges++;
			after_reset = reset;
		end else begin
			assert ($countones(diff) <= 1)
				else stop_with_failure("Two pads changed on one edge.");
			if (diff[2] || diff[1]) begin
				if (char_bits == 8) begin
					stop_with_failure("A ninth data bit arrived before the character end toggle.");
				end else begin
					char_val = {char_val[6:0], diff[2]};
					char_bits++;
				end
			end
			if (diff[0]) begin
				if (char_bits == 8) begin
					match_pad_event("pad character", int'(char_val));
				end else if (char_bits == 0) begin
					match_pad_event("eci_pad end mark", end_mark);
				end else begin
					stop_with_failure("eci_pad toggled in the middle of a character.");
				end
				char_bits = 0;
			end
		end
		prev_pads = pads;
	end

	// Acknowledge monitor with the hold check for back-pressure.
	always @(posedge clk) begin
		logic [15:0] expected;
		if (!reset) begin
			if (ack_hold) begin
				assert (ack_valid) else report_mismatch("ack_valid", 1, int'(ack_valid));
				assert (ack_data == held_data)
					else report_mismatch("ack_data", int'(held_data), int'(ack_data));
				assert (ack_last == held_last)
					else report_mismatch("ack_last", int'(held_last), int'(ack_last));
			end
			ack_hold = ack_valid && !ack_ready;
			held_data = ack_data;
			held_last = ack_last;
			if (ack_valid && ack_ready) begin
				if (ack_q.size() == 0) begin
					stop_with_failure("An acknowledge byte arrived with no frame waiting for one.");
				end else begin
					expected = ack_q[0];
					if (ack_second) begin
						assert (ack_data == expected[7:0])
							else report_mismatch("ack_data", int'(expected[7:0]), int'(ack_data));
						assert (ack_last) else report_mismatch("ack_last", 1, int'(ack_last));
						void'(ack_q.pop_front());
						acks_seen <= acks_seen + 1;
					end else begin
						assert (ack_data == expected[15:8])
							else report_mismatch("ack_data", int'(expected[15:8]), int'(ack_data));
						assert (!ack_last) else report_mismatch("ack_last", 0, int'(ack_last));
					end
					ack_second = !ack_second;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > timeout_limit) begin
			stop_with_failure($sformatf("Timeout after %0d cycles with %0d of %0d acknowledges.",
				cycle_cnt, acks_seen, ack_total));
		end
	end

endmodule

// ==== ein_int.f ====
source/ein_pkg.sv
source/frame_buffer.sv
source/header_decoder.sv
source/ein_modulator.sv
source/ack_generator.sv
source/ein_int.sv
testbench/ein_int_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ein_int_tb -f ein_int.f \
	--Mdir obj_dir -o ein_int_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi
./obj_dir/ein_int_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
if ! grep -qx "sim passed" sim.log; then
	echo "Pass line not found in sim.log"
	exit 1
fi
exit 0
